/* verilog/board_pkg.sv */
// Board constants assume a 50 MHz clock, six static HEX digits and a left-only INMP441
package board_pkg;

    localparam int clk_mhz          = 50;
    localparam int w_key            = 4;
    localparam int w_sw             = 10;
    localparam int w_led            = 10;
    localparam int w_digit          = 6;
    localparam int w_top_sw         = w_sw - 1;         // sw[9] is the reset
    localparam int w_meter          = w_led - w_digit;  // Upper LEDs carry the dots

    // I2S timing
    localparam int sck_khz          = 3125;
    localparam int sck_half_period  = clk_mhz * 1000 / (2 * sck_khz);
    localparam int bits_per_channel = 32;
    localparam int w_sample         = 24;

    localparam int scan_period      = 16;               // Clocks per digit
    localparam int meter_top_exp    = 22;               // Threshold exponent of LED 0
    localparam int meter_step       = 2;

    typedef logic signed [w_sample-1:0] mic_sample_t;
    typedef logic        [6:0]          seg7_t;         // Active low, a in bit 0
    typedef logic        [7:0]          abcdefgh_t;     // Active high, a in MSB, dp in LSB
    typedef logic        [w_digit-1:0]  digit_sel_t;    // One-hot

    typedef enum logic [1:0]
    {
        rx_wait_ws,
        rx_delay,
        rx_shift,
        rx_frame
    } rx_state_t;

    // Active-high abcdefg pattern, a in bit 6
    function automatic logic [6:0] hex_font(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b1111110;
            4'h1: return 7'b0110000;
            4'h2: return 7'b1101101;
            4'h3: return 7'b1111001;
            4'h4: return 7'b0110011;
            4'h5: return 7'b1011011;
            4'h6: return 7'b1011111;
            4'h7: return 7'b1110000;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1111011;
            4'ha: return 7'b1110111;
            4'hb: return 7'b0011111;
            4'hc: return 7'b1001110;
            4'hd: return 7'b0111101;
            4'he: return 7'b1001111;
            default: return 7'b1000111;
        endcase
    endfunction

endpackage

/* verilog/inmp441_mic_i2s_receiver.sv */
// Left channel only, sck fixed at clk / 16, sample valid on the value_strobe cycle
`timescale 1ns/1ps

module inmp441_mic_i2s_receiver
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sd,
    output logic        sck,
    output logic        ws,
    output logic        lr,
    output mic_sample_t value,
    output logic        value_strobe
);

    logic [$clog2(sck_half_period)-1:0]      half_cnt;
    logic [$clog2(2 * bits_per_channel)-1:0] bit_cnt;   // Bit position in the frame
    logic [$clog2(w_sample)-1:0]             bit_idx;
    logic [w_sample-1:0]                     shift;
    logic [w_sample-1:0]                     shift_next;
    logic                                    sck_edge;
    logic                                    sck_rise;
    logic                                    sck_fall;
    rx_state_t                               state;

    //------------------------------------------------------------------------
    // Bit clock and word select

    assign sck_edge = (half_cnt == sck_half_period - 1);
    assign sck_rise = sck_edge & ~sck;
    assign sck_fall = sck_edge &  sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            half_cnt <= '0;
            sck      <= 1'b0;
            bit_cnt  <= '0;
        end
        else
        begin
            half_cnt <= sck_edge ? '0 : half_cnt + 1'b1;

            if (sck_edge)
                sck <= ~sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;  // ws follows the MSB
        end
    end

    assign ws = bit_cnt[$high(bit_cnt)];   // Low for the left half frame
    assign lr = 1'b0;                       // Microphone answers in the left slot

    //------------------------------------------------------------------------
    // Capture FSM

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state        <= rx_wait_ws;
            bit_idx      <= '0;
            value_strobe <= 1'b0;
        end
        else
        begin
            value_strobe <= 1'b0;

            case (state)
                rx_wait_ws:
                    if (bit_cnt == '0)      // First clock of the left half
                        state <= rx_delay;
                rx_delay:
                    if (sck_rise)           // One-bit I2S delay, nothing to keep
                    begin
                        state   <= rx_shift;
                        bit_idx <= '0;
                    end
                rx_shift:
                    if (sck_rise)
                    begin
                        if (bit_idx == w_sample - 1)
                        begin
                            state        <= rx_frame;
                            value_strobe <= 1'b1;
                        end
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                rx_frame:
                    if (ws)
                        state <= rx_wait_ws;
                default:
                    state <= rx_wait_ws;
            endcase
        end
    end

    assign shift_next = {shift[w_sample-2:0], sd};  // MSB first

    always_ff @(posedge clk)
    begin
        if (state == rx_shift && sck_rise)
            shift <= shift_next;

        if (state == rx_shift && sck_rise && bit_idx == w_sample - 1)
            value <= shift_next;
    end

endmodule

/* verilog/seven_segment_scanner.sv */
// Digit i shows nibble i of number for scan_period clocks, dp only on digit 5
`timescale 1ns/1ps

module seven_segment_scanner
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  mic_sample_t number,
    input  logic        dot,
    output abcdefgh_t   abcdefgh,
    output digit_sel_t  digit
);

    logic [$clog2(scan_period)-1:0] dwell;
    logic [3:0]                     nibble;
    logic                           advance;

    //------------------------------------------------------------------------
    // Digit rotation

    assign advance = (dwell == scan_period - 1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dwell <= '0;
            digit <= digit_sel_t'(1);       // Start on digit 0
        end
        else
        begin
            dwell <= advance ? '0 : dwell + 1'b1;

            if (advance)
                digit <= {digit[w_digit-2:0], digit[w_digit-1]};
        end
    end

    //------------------------------------------------------------------------
    // Segment pattern of the selected digit

    always_comb
    begin
        nibble = 4'h0;

        for (int i = 0; i < w_digit; i++)
        begin
            if (digit[i])
                nibble = number[i * 4 +: 4];
        end
    end

    assign abcdefgh[7:1] = hex_font(nibble);
    assign abcdefgh[0]   = dot & digit[w_digit-1];   // Sign point on the leftmost digit

endmodule

/* verilog/top.sv */
// Only key[0] (hold) and sw[0] (meter mute) have a function, the other inputs are spare
`timescale 1ns/1ps

module top
    import board_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [w_key-1:0]    key,
    input  logic [w_top_sw-1:0] sw,
    input  mic_sample_t         mic,
    input  logic                mic_strobe,
    output logic [w_meter-1:0]  led,
    output abcdefgh_t           abcdefgh,
    output digit_sel_t          digit
);

    mic_sample_t         hold;
    logic [w_sample-1:0] magnitude;
    logic [w_meter-1:0]  meter;
    logic                dot;

    // Display value, frozen while key 0 is pressed
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            hold <= '0;
        else if (mic_strobe && !key[0])
            hold <= mic;
    end

    assign dot       = hold[w_sample-1];            // Negative sample
    assign magnitude = dot ? -hold : hold;          // Full scale negative still fits

    //------------------------------------------------------------------------
    // Level meter, LED k at 2 ** (22 - 2k)

    always_comb
    begin
        for (int k = 0; k < w_meter; k++)
            meter[k] = (magnitude >= (1 << (meter_top_exp - meter_step * k)));
    end

    assign led = sw[0] ? '0 : meter;                // Mute

    //------------------------------------------------------------------------

    seven_segment_scanner scanner_inst
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .number   ( hold     ),
        .dot      ( dot      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

/* verilog/static_digit_latches.sv */
// Needs a one-hot digit select, a digit stays blank until it is first scanned
`timescale 1ns/1ps

module static_digit_latches
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  abcdefgh_t  abcdefgh,
    input  digit_sel_t digit,
    output seg7_t      hex [w_digit],
    output logic [w_digit-1:0] dp
);

    logic [7:0] hgfedcba;

    //------------------------------------------------------------------------
    // Reverse the bus so that segment a lands in bit 0

    always_comb
    begin
        for (int i = 0; i < 8; i++)
            hgfedcba[i] = abcdefgh[7 - i];
    end

    //------------------------------------------------------------------------
    // One latch per digit, loaded while that digit is selected

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int d = 0; d < w_digit; d++)
                hex[d] <= '1;               // Blank
            dp <= '0;
        end
        else
        begin
            for (int d = 0; d < w_digit; d++)
            begin
                if (digit[d])
                begin
                    hex[d] <= ~hgfedcba[6:0];   // Board segments are active low
                    dp[d]  <=  hgfedcba[7];
                end
            end
        end
    end

endmodule

/* verilog/board_specific_top.sv */
// sw[9] is the reset, keys are active low, HEX dots are shown on ledr[9:4]
`timescale 1ns/1ps

module board_specific_top
    import board_pkg::*;
(
    input  logic             clk,
    input  logic [w_key-1:0] key,
    input  logic [w_sw-1:0]  sw,
    output logic [w_led-1:0] ledr,
    output seg7_t            hex0,
    output seg7_t            hex1,
    output seg7_t            hex2,
    output seg7_t            hex3,
    output seg7_t            hex4,
    output seg7_t            hex5,
    output logic             mic_sck,
    output logic             mic_ws,
    output logic             mic_lr,
    input  logic             mic_sd
);

    logic                rst;
    logic [w_top_sw-1:0] top_sw;
    logic [w_key-1:0]    top_key;
    logic [w_meter-1:0]  top_led;
    mic_sample_t         mic;
    logic                mic_strobe;
    abcdefgh_t           abcdefgh;
    digit_sel_t          digit;
    seg7_t               hex [w_digit];
    logic [w_digit-1:0]  dp;

    assign rst     = sw[w_sw-1];
    assign top_sw  = sw[w_top_sw-1:0];
    assign top_key = ~key;                          // Pressed key reads as 1

    //------------------------------------------------------------------------

    inmp441_mic_i2s_receiver mic_inst
    (
        .clk          ( clk        ),
        .rst          ( rst        ),
        .sd           ( mic_sd     ),
        .sck          ( mic_sck    ),
        .ws           ( mic_ws     ),
        .lr           ( mic_lr     ),
        .value        ( mic        ),
        .value_strobe ( mic_strobe )
    );

    top top_inst
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .key        ( top_key    ),
        .sw         ( top_sw     ),
        .mic        ( mic        ),
        .mic_strobe ( mic_strobe ),
        .led        ( top_led    ),
        .abcdefgh   ( abcdefgh   ),
        .digit      ( digit      )
    );

    static_digit_latches latches_inst
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .hex      ( hex      ),
        .dp       ( dp       )
    );

    //------------------------------------------------------------------------
    // Board outputs

    assign ledr = {dp, top_led};                    // Dots above the meter

    assign hex0 = hex[0];
    assign hex1 = hex[1];
    assign hex2 = hex[2];
    assign hex3 = hex[3];
    assign hex4 = hex[4];
    assign hex5 = hex[5];

endmodule

/* tests/i2s_mic_model.sv */
// Behavioral INMP441 with 24-bit words, a word is taken at its MSB slot and later slots read low
`timescale 1ns/1ps

module i2s_mic_model
    import board_pkg::*;
(
    input  logic                rst,
    input  logic                sck,
    input  logic                ws,
    input  logic [w_sample-1:0] left,
    input  logic [w_sample-1:0] right,
    output logic                sd
);

    logic [w_sample-1:0] word;      // Word of the current half frame
    logic                ws_prev;
    int                  pos;       // Bit slot since the last ws edge

    initial
    begin
        word    = '0;
        ws_prev = 1'b0;
        pos     = 0;
        sd      = 1'b0;
    end

    // Data changes on sck falling, MSB one slot after each ws edge
    always @(negedge sck or posedge rst)
    begin
        if (rst)
        begin
            pos     = 0;
            ws_prev = 1'b0;
            sd      = 1'b0;
        end
        else
        begin
            #1;                             // ws moves on the same clock edge
            pos     = (ws != ws_prev) ? 0 : pos + 1;
            ws_prev = ws;

            if (pos == 1)
                word = ws ? right : left;

            sd = (pos >= 1 && pos <= w_sample) ? word[w_sample - pos] : 1'b0;
        end
    end

endmodule

/* tests/tb_board_specific_top.sv */
// Directed tests of the board top, outputs are sampled on the falling clock edge
`timescale 1ns/1ps

module tb_board_specific_top
    import board_pkg::*;
();

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 16;
    localparam int frame_cycles    = 2 * bits_per_channel * 2 * sck_half_period;
    localparam int test_count      = 6;
    localparam int frames_per_test = 3;
    localparam int watchdog_cycles = test_count * frames_per_test * frame_cycles * 3;

    logic                clk;
    logic [w_key-1:0]    key;
    logic [w_sw-1:0]     sw;
    logic [w_led-1:0]    ledr;
    seg7_t               hex0;
    seg7_t               hex1;
    seg7_t               hex2;
    seg7_t               hex3;
    seg7_t               hex4;
    seg7_t               hex5;
    logic                mic_sck;
    logic                mic_ws;
    logic                mic_lr;
    logic                mic_sd;
    logic [w_sample-1:0] left_word;
    logic [w_sample-1:0] right_word;
    mic_sample_t         shown;             // Sample the display should show
    seg7_t               hex_out [w_digit];
    int                  errors;

    assign hex_out[0] = hex0;
    assign hex_out[1] = hex1;
    assign hex_out[2] = hex2;
    assign hex_out[3] = hex3;
    assign hex_out[4] = hex4;
    assign hex_out[5] = hex5;

    //------------------------------------------------------------------------
    // DUT and microphone

    board_specific_top board_specific_top_inst
    (
        .clk     ( clk     ),
        .key     ( key     ),
        .sw      ( sw      ),
        .ledr    ( ledr    ),
        .hex0    ( hex0    ),
        .hex1    ( hex1    ),
        .hex2    ( hex2    ),
        .hex3    ( hex3    ),
        .hex4    ( hex4    ),
        .hex5    ( hex5    ),
        .mic_sck ( mic_sck ),
        .mic_ws  ( mic_ws  ),
        .mic_lr  ( mic_lr  ),
        .mic_sd  ( mic_sd  )
    );

    i2s_mic_model mic_model_inst
    (
        .rst   ( sw[w_sw-1] ),
        .sck   ( mic_sck    ),
        .ws    ( mic_ws     ),
        .left  ( left_word  ),
        .right ( right_word ),
        .sd    ( mic_sd     )
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    //------------------------------------------------------------------------
    // Expected values

    // Active-low gfedcba pattern, segment a in bit 0
    function automatic seg7_t hex_pattern(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    // Meter on ledr[3:0], sign point of digit 5 on ledr[9]
    function automatic logic [w_led-1:0] led_pattern(input mic_sample_t sample,
                                                     input logic mute);
        logic [w_led-1:0] leds;
        int               magnitude;
        leds      = '0;
        magnitude = int'(sample);
        if (magnitude < 0)
            magnitude = -magnitude;
        for (int k = 0; k < w_meter; k++)
            leds[k] = !mute && (magnitude >= (1 << (22 - 2 * k)));
        leds[w_led-1] = sample[w_sample-1];
        return leds;
    endfunction

    task automatic check_hex(input string test, input int index,
                             input seg7_t expected, input seg7_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("Mismatch in %s: hex%0d expected %b, actual %b",
                     test, index, expected, actual);
        end
    endtask

    task automatic check_leds(input string test, input logic [w_led-1:0] expected,
                              input logic [w_led-1:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("Mismatch in %s: ledr expected %b, actual %b", test, expected, actual);
        end
    endtask

    task automatic check_level(input string test, input string name,
                               input logic expected, input logic actual);
        if (actual !== expected)
        begin
            errors++;
            $display("Mismatch in %s: %s expected %b, actual %b",
                     test, name, expected, actual);
        end
    endtask

    task automatic check_display(input string test, input mic_sample_t sample,
                                 input logic mute);
        for (int i = 0; i < w_digit; i++)
            check_hex(test, i, hex_pattern(sample[i * 4 +: 4]), hex_out[i]);
        check_leds(test, led_pattern(sample, mute), ledr);
    endtask

    task automatic check_blank(input string test);
        for (int i = 0; i < w_digit; i++)
            check_hex(test, i, '1, hex_out[i]);
        check_leds(test, '0, ledr);
    endtask

    task automatic wait_frames(input int count);
        repeat (count) @(negedge mic_ws);
        @(negedge clk);
    endtask

    // New left word, checked once a whole frame has carried it
    task automatic send_left(input mic_sample_t word);
        @(posedge clk);
        left_word <= word;
        wait_frames(2);
    endtask

    //------------------------------------------------------------------------
    // Tests

    task automatic reset_state();
        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        check_blank("reset_state");
        @(posedge clk);
        sw[w_sw-1] <= 1'b0;
        @(negedge clk);
        check_blank("reset_state");
        check_level("reset_state", "mic_sck", 1'b0, mic_sck);
        check_level("reset_state", "mic_ws", 1'b0, mic_ws);
        check_level("reset_state", "mic_lr", 1'b0, mic_lr);
    endtask

    task automatic positive_sample();
        logic [31:0] draw;
        mic_sample_t word;
        draw = $urandom;
        word = {1'b0, draw[w_sample-2:0]};
        send_left(word);
        shown = word;
        check_display("positive_sample", shown, 1'b0);
    endtask

    task automatic negative_sample();
        logic [31:0] draw;
        mic_sample_t word;
        draw = $urandom;
        word = {1'b1, draw[w_sample-2:0]};
        send_left(word);
        shown = word;
        check_display("negative_sample", shown, 1'b0);
    endtask

    task automatic hold_key();
        logic [31:0] draw;
        mic_sample_t word;
        draw = $urandom;
        word = draw[w_sample-1:0];
        @(posedge clk);
        key[0] <= 1'b0;                     // Board keys are active low
        send_left(word);
        check_display("hold_key", shown, 1'b0);
        @(posedge clk);
        key[0] <= 1'b1;
        wait_frames(1);
        shown = word;
        check_display("hold_key", shown, 1'b0);
    endtask

    task automatic right_channel_and_mute();
        logic [31:0] draw;
        draw = $urandom;
        @(posedge clk);
        right_word <= draw[w_sample-1:0];
        wait_frames(2);
        check_display("right_channel_ignored", shown, 1'b0);
        @(posedge clk);
        sw[0] <= 1'b1;
        @(negedge clk);
        check_display("mute", shown, 1'b1);
        @(posedge clk);
        sw[0] <= 1'b0;
    endtask

    task automatic mid_run_reset();
        logic [31:0] draw;
        mic_sample_t word;
        draw = $urandom;
        word = draw[w_sample-1:0];
        @(posedge clk);
        sw[w_sw-1] <= 1'b1;
        left_word  <= word;
        @(negedge clk);
        check_blank("mid_run_reset");
        repeat (reset_cycles) @(posedge clk);
        sw[w_sw-1] <= 1'b0;
        wait_frames(1);                     // First frame starts at release
        shown = word;
        check_display("mid_run_reset", shown, 1'b0);
    endtask

    //------------------------------------------------------------------------

    initial
    begin
        void'($urandom(63112));
        errors     = 0;
        key        = '1;
        sw         = '0;
        sw[w_sw-1] = 1'b1;
        left_word  = '0;
        right_word = '0;
        shown      = '0;

        reset_state();
        positive_sample();
        negative_sample();
        hold_key();
        right_channel_and_mute();
        mid_run_reset();

        $display("Closing count: %0d errors over %0d tests", errors, test_count);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* build.f */
verilog/board_pkg.sv
verilog/inmp441_mic_i2s_receiver.sv
verilog/seven_segment_scanner.sv
verilog/top.sv
verilog/static_digit_latches.sv
verilog/board_specific_top.sv
tests/i2s_mic_model.sv
tests/tb_board_specific_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compiles and runs the testbench with Verilator, fails on the fail message in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f \
    --top-module tb_board_specific_top --Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "ERRORS FOUND" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
